/* common/etx_cfg.svh */
// ##################################################
// build-time constants for the mesh tx link
// ##################################################
`ifndef ETX_CFG_SVH
`define ETX_CFG_SVH

// register field address width
// mi_addr carries two more bits for byte lanes
`define ETX_RFAW 6

// entries per source queue
// also the credits a source holds after reset
`define ETX_QUEUE_DEPTH 4

// local chip id, matched against dstaddr[31:20]
// beats to this id skip the monitor
`define ETX_ID 12'h3e7

// version register value out of reset
`define ETX_DEFAULT_VERSION 16'h0102

`endif

/* common/etx_pkg.sv */
// ##################################################
// mesh packet struct, source index and register map
// ##################################################
package etx_pkg;

   // ##################################################
   // mesh packet, 104 bits flat
   // ##################################################
   // first member sits in the top bits
   typedef struct packed {
      logic [31:0] srcaddr;  // bits 103:72
      logic [31:0] data;     // bits 71:40
      logic [31:0] dstaddr;  // bits 39:8, chip id on top
      logic [4:0]  ctrlmode; // bits 7:3
      logic [1:0]  datamode; // bits 2:1
      logic        write;    // bit 0
   } etx_packet_t;

   // ##################################################
   // transmit sources
   // ##################################################
   typedef enum logic {
      ETX_SRC_WR = 1'b0,     // write transactions
      ETX_SRC_RD = 1'b1      // read requests
   } etx_src_t;

   // ##################################################
   // register word indexes
   // ##################################################
   typedef enum logic [3:0] {
      ETX_REG_VERSION = 4'd0,
      ETX_REG_CFG     = 4'd1,
      ETX_REG_STATUS  = 4'd2,
      ETX_REG_GPIO    = 4'd3,
      ETX_REG_MONITOR = 4'd4,
      ETX_REG_PACKET  = 4'd5 // last sampled dstaddr
   } etx_reg_t;

endpackage

/* common/mi_if.sv */
// ##################################################
// memory interface bundle for register access
// ##################################################
`timescale 1ns/1ps
`include "etx_cfg.svh"

interface mi_if;
   logic                  mi_en;   // access strobe
   logic                  mi_we;   // write when set, read otherwise
   logic [`ETX_RFAW+1:0]  mi_addr; // byte address
   logic [31:0]           mi_din;  // write data
   logic [31:0]           mi_dout; // read data, one cycle after the read

   // host side drives the request
   modport host (
      output mi_en, mi_we, mi_addr, mi_din,
      input  mi_dout
   );

   // register file answers
   modport regfile (
      input  mi_en, mi_we, mi_addr, mi_din,
      output mi_dout
   );
endinterface

/* verilog/etx_queue.sv */
// ##################################################
// credit-returning packet fifo, one per source
// ##################################################
`timescale 1ns/1ps
`include "etx_cfg.svh"

module etx_queue import etx_pkg::*; (
   input  logic        clk,
   input  logic        nreset,
   input  logic        access,     // push, source holds a credit
   input  etx_packet_t packet,
   output logic        credit,     // one credit back per pop
   input  logic        pop,
   output logic        head_valid,
   output etx_packet_t head
);

   localparam int DEPTH = `ETX_QUEUE_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   etx_packet_t   mem [DEPTH]; // no reset on payload
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_pop;

   assign do_pop     = pop & head_valid; // ignore pops on empty
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];
   assign credit     = do_pop;           // entry leaves, slot freed

   // storage write
   always_ff @(posedge clk) begin
      if (access)
         mem[wr_ptr] <= packet;
   end

   // ##################################################
   // pointers and occupancy
   // ##################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (access)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({access, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

/* verilog/etx_arbiter.sv */
// ##################################################
// round-robin pick of two queue heads onto tx output
// ##################################################
`timescale 1ns/1ps

module etx_arbiter import etx_pkg::*; (
   input  logic        clk,
   input  logic        nreset,
   input  logic [1:0]  head_valid,
   input  etx_packet_t head [2],
   output logic [1:0]  pop,
   input  logic        tx_enable,
   input  logic        ctrlmode_bypass,
   input  logic [3:0]  ctrlmode,       // override for low ctrlmode bits
   input  logic        tx_wait,
   output logic        tx_access,
   output etx_packet_t tx_packet,
   output logic        beat            // beat completes this edge
);

   etx_src_t    sel;      // source picked this cycle
   etx_src_t    last;     // previous winner
   etx_packet_t next_pkt;
   logic        tx_free;
   logic        load;

   assign beat    = tx_access & ~tx_wait;
   assign tx_free = ~tx_access | beat;  // empty or draining now
   assign load    = tx_free & tx_enable & (|head_valid);

   // ##################################################
   // source select
   // ##################################################
   always_comb begin
      if (&head_valid)
         sel = (last == ETX_SRC_WR) ? ETX_SRC_RD : ETX_SRC_WR; // alternate
      else if (head_valid[ETX_SRC_RD])
         sel = ETX_SRC_RD;
      else
         sel = ETX_SRC_WR;
   end

   always_comb begin
      pop      = '0;
      pop[sel] = load;  // pop the head we load
   end

   // ctrlmode substitution, top bit passes
   always_comb begin
      next_pkt = head[sel];
      if (ctrlmode_bypass)
         next_pkt.ctrlmode[3:0] = ctrlmode;
   end

   // ##################################################
   // output register
   // ##################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         tx_access <= 1'b0;
         last      <= ETX_SRC_RD;  // write queue wins first tie
      end else if (load) begin
         tx_access <= 1'b1;
         last      <= sel;
      end else if (beat) begin
         tx_access <= 1'b0;        // done, nothing to follow
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         tx_packet <= next_pkt;    // holds through tx_wait
   end

endmodule

/* etx_cfg/etx_cfg.sv */
// ##################################################
// tx config/status registers, monitor and sampler
// ##################################################
`timescale 1ns/1ps
`include "etx_cfg.svh"

module etx_cfg import etx_pkg::*; (
   input  logic        clk,
   input  logic        nreset,
   mi_if.regfile       mi,
   input  logic [15:0] tx_status,       // async link status
   input  logic        beat,            // completing tx beat
   input  etx_packet_t tx_packet,
   output logic        tx_enable,
   output logic        mmu_enable,
   output logic        remap_enable,
   output logic        gpio_enable,
   output logic        burst_enable,
   output logic        ctrlmode_bypass,
   output logic [8:0]  gpio_data,
   output logic [3:0]  ctrlmode
);

   logic [`ETX_RFAW-1:0] reg_idx;      // word index
   logic                 reg_wr;
   logic                 reg_rd;
   logic                 wr_version;
   logic                 wr_cfg;
   logic                 wr_status;
   logic                 wr_gpio;
   logic                 wr_monitor;
   logic [15:0]          version_reg;
   logic [11:0]          cfg_reg;
   logic [8:0]           gpio_reg;
   logic [15:0]          status_reg;
   logic [15:0]          status_meta;  // first sync stage
   logic [15:0]          status_sync;
   logic [31:0]          monitor_reg;
   logic [31:0]          packet_reg;
   logic                 count_beat;

   // ##################################################
   // decode
   // ##################################################
   assign reg_idx    = mi.mi_addr[`ETX_RFAW+1:2];
   assign reg_wr     = mi.mi_en & mi.mi_we;
   assign reg_rd     = mi.mi_en & ~mi.mi_we;
   assign wr_version = reg_wr & (reg_idx == ETX_REG_VERSION);
   assign wr_cfg     = reg_wr & (reg_idx == ETX_REG_CFG);
   assign wr_status  = reg_wr & (reg_idx == ETX_REG_STATUS);
   assign wr_gpio    = reg_wr & (reg_idx == ETX_REG_GPIO);
   assign wr_monitor = reg_wr & (reg_idx == ETX_REG_MONITOR);

   // ##################################################
   // config, version, gpio
   // ##################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         cfg_reg     <= '0;                    // tx off
         version_reg <= `ETX_DEFAULT_VERSION;
         gpio_reg    <= '0;
      end else begin
         if (wr_cfg)     cfg_reg     <= mi.mi_din[11:0];
         if (wr_version) version_reg <= mi.mi_din[15:0];
         if (wr_gpio)    gpio_reg    <= mi.mi_din[8:0];
      end
   end

   assign tx_enable       = cfg_reg[0];
   assign mmu_enable      = cfg_reg[1];
   assign remap_enable    = (cfg_reg[3:2] == 2'b01);
   assign ctrlmode        = cfg_reg[7:4];
   assign ctrlmode_bypass = cfg_reg[8];
   assign gpio_enable     = (cfg_reg[10:9] == 2'b01);
   assign burst_enable    = cfg_reg[11];
   assign gpio_data       = gpio_reg;

   // ##################################################
   // sticky status, two-flop sync in front
   // ##################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         status_meta <= '0;
         status_sync <= '0;
         status_reg  <= '0;
      end else begin
         status_meta <= tx_status;
         status_sync <= status_meta;
         if (wr_status)
            status_reg <= mi.mi_din[15:0];       // write clears or sets
         else
            status_reg <= status_reg | status_sync; // bits stick
      end
   end

   // foreign beat while status 7:6 quiet
   assign count_beat = beat & (tx_packet.dstaddr[31:20] != `ETX_ID)
                       & ~(|status_sync[7:6]);

   // monitor counter
   always_ff @(posedge clk) begin
      if (!nreset)
         monitor_reg <= '0;
      else if (wr_monitor)
         monitor_reg <= mi.mi_din;
      else if (count_beat)
         monitor_reg <= monitor_reg + 1'b1;
   end

   // last counted destination
   always_ff @(posedge clk) begin
      if (count_beat)
         packet_reg <= tx_packet.dstaddr;
   end

   // ##################################################
   // readback, one cycle after the read
   // ##################################################
   always_ff @(posedge clk) begin
      if (!nreset)
         mi.mi_dout <= '0;
      else if (reg_rd)
         case (reg_idx)
            ETX_REG_VERSION: mi.mi_dout <= {16'b0, version_reg};
            ETX_REG_CFG:     mi.mi_dout <= {21'b0, cfg_reg[10:0]}; // burst hidden
            ETX_REG_STATUS:  mi.mi_dout <= {16'b0, status_reg};
            ETX_REG_GPIO:    mi.mi_dout <= {23'b0, gpio_reg};
            ETX_REG_MONITOR: mi.mi_dout <= monitor_reg;
            ETX_REG_PACKET:  mi.mi_dout <= packet_reg;
            default:         mi.mi_dout <= '0;
         endcase
      else
         mi.mi_dout <= '0;   // idle bus reads zero
   end

endmodule

/* verilog/etx_top.sv */
// ##################################################
// mesh tx top, source queues, arbiter and registers
// ##################################################
`timescale 1ns/1ps
`include "etx_cfg.svh"

module etx_top import etx_pkg::*; (
   input  logic                 clk,
   input  logic                 nreset,
   // register access
   input  logic                 mi_en,
   input  logic                 mi_we,
   input  logic [`ETX_RFAW+1:0] mi_addr,
   input  logic [31:0]          mi_din,
   output logic [31:0]          mi_dout,
   // write transaction source
   input  logic                 wr_access,
   input  etx_packet_t          wr_packet,
   output logic                 wr_credit,
   // read request source
   input  logic                 rd_access,
   input  etx_packet_t          rd_packet,
   output logic                 rd_credit,
   // link side
   output logic                 tx_access,
   output etx_packet_t          tx_packet,
   input  logic                 tx_wait,
   input  logic [15:0]          tx_status,
   // decoded config
   output logic                 tx_enable,
   output logic                 mmu_enable,
   output logic                 remap_enable,
   output logic                 gpio_enable,
   output logic                 burst_enable,
   output logic [8:0]           gpio_data
);

   mi_if        mi ();
   logic [1:0]  head_valid;
   etx_packet_t head [2];
   logic [1:0]  pop;
   logic        beat;
   logic        ctrlmode_bypass;
   logic [3:0]  ctrlmode;

   // host side of the register bus
   assign mi.mi_en   = mi_en;
   assign mi.mi_we   = mi_we;
   assign mi.mi_addr = mi_addr;
   assign mi.mi_din  = mi_din;
   assign mi_dout    = mi.mi_dout;

   etx_queue u_wr_queue (
      .clk, .nreset, .access(wr_access), .packet(wr_packet), .credit(wr_credit),
      .pop(pop[ETX_SRC_WR]), .head_valid(head_valid[ETX_SRC_WR]),
      .head(head[ETX_SRC_WR])
   );

   etx_queue u_rd_queue (
      .clk, .nreset, .access(rd_access), .packet(rd_packet), .credit(rd_credit),
      .pop(pop[ETX_SRC_RD]), .head_valid(head_valid[ETX_SRC_RD]),
      .head(head[ETX_SRC_RD])
   );

   etx_arbiter u_arbiter (
      .clk, .nreset, .head_valid, .head, .pop, .tx_enable, .ctrlmode_bypass,
      .ctrlmode, .tx_wait, .tx_access, .tx_packet, .beat
   );

   etx_cfg u_cfg (
      .clk, .nreset, .mi(mi.regfile), .tx_status, .beat, .tx_packet,
      .tx_enable, .mmu_enable, .remap_enable, .gpio_enable, .burst_enable,
      .ctrlmode_bypass, .gpio_data, .ctrlmode
   );

endmodule

/* dv/etx_tb.sv */
// ##################################################
// tx link testbench, random traffic vs model
// ##################################################
`timescale 1ns/1ps
`include "etx_cfg.svh"

module etx_tb import etx_pkg::*; ();

   localparam int CLK_PERIOD   = 20;
   localparam int RFAW         = `ETX_RFAW;
   localparam int DEPTH        = `ETX_QUEUE_DEPTH;
   localparam int REG_OPS      = 40;
   localparam int PHASE_CYCLES = 200;   // traffic cycles per phase
   localparam int DRAIN_LIMIT  = 400;   // cycles allowed to empty the link
   localparam int TOTAL_CYCLES = 6 * PHASE_CYCLES + 5 * DRAIN_LIMIT + REG_OPS * 16;
   localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD;

   logic              clk;
   logic              nreset;
   logic              mi_en;
   logic              mi_we;
   logic [RFAW+1:0]   mi_addr;
   logic [31:0]       mi_din;
   logic [31:0]       mi_dout;
   logic              wr_access;
   etx_packet_t       wr_packet;
   logic              wr_credit;
   logic              rd_access;
   etx_packet_t       rd_packet;
   logic              rd_credit;
   logic              tx_access;
   etx_packet_t       tx_packet;
   logic              tx_wait;
   logic [15:0]       tx_status;
   logic              tx_enable;
   logic              mmu_enable;
   logic              remap_enable;
   logic              gpio_enable;
   logic              burst_enable;
   logic [8:0]        gpio_data;

   // ##################################################
   // model state
   // ##################################################
   logic [31:0]  rng_state;
   int           credits [2];     // credits held by each source
   etx_packet_t  exp_wr [$];      // packets owed by the write queue
   etx_packet_t  exp_rd [$];
   logic [11:0]  cfg_sh;
   logic [8:0]   gpio_sh;
   logic [15:0]  version_sh;
   logic [15:0]  status_sh;
   logic [31:0]  mon_exp;
   logic [31:0]  last_dst;
   logic         last_dst_valid;
   logic         status_quiet;    // driven status 7:6 clear and settled
   int           beats;
   logic         held;            // wait stalled the output last cycle
   etx_packet_t  prev_pkt;
   logic         read_prev;

   etx_top DUT (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ##################################################
   // helpers
   // ##################################################
   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic etx_packet_t make_packet(input logic src);
      etx_packet_t p;
      logic [31:0] r;
      r = xorshift32();
      p.write    = ~src;                      // reads carry write clear
      p.datamode = r[1:0];
      p.ctrlmode = r[6:2];
      p.data     = xorshift32();
      p.dstaddr  = xorshift32();
      if (r[9:8] == 2'b00)
         p.dstaddr[31:20] = `ETX_ID;          // some local beats
      p.srcaddr  = {src, r[30:0]};            // top bit tags the source
      return p;
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [103:0] exp,
                              input logic [103:0] act);
      assert (act === exp) else begin
         fail_run($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
      end
   endtask

   task automatic reg_write(input logic [3:0] idx, input logic [31:0] data);
      @(posedge clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b1;
      mi_addr <= {RFAW'(idx), 2'b00};
      mi_din  <= data;
      @(posedge clk);
      mi_en   <= 1'b0;
      mi_we   <= 1'b0;
      case (idx)                              // register now holds data
         ETX_REG_CFG:     cfg_sh     = data[11:0];
         ETX_REG_GPIO:    gpio_sh    = data[8:0];
         ETX_REG_VERSION: version_sh = data[15:0];
         ETX_REG_STATUS:  status_sh  = data[15:0];
         ETX_REG_MONITOR: mon_exp    = data;
         default:         ;
      endcase
   endtask

   task automatic reg_read(input logic [3:0] idx, output logic [31:0] data);
      @(posedge clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= {RFAW'(idx), 2'b00};
      @(posedge clk);
      mi_en   <= 1'b0;
      @(negedge clk);                         // response cycle
      data = mi_dout;
   endtask

   task automatic check_reg(input string name, input logic [3:0] idx,
                            input logic [31:0] exp);
      logic [31:0] data;
      reg_read(idx, data);
      check_value(name, exp, data);
   endtask

   task automatic check_decoded();
      @(negedge clk);
      check_value("tx_enable", cfg_sh[0], tx_enable);
      check_value("mmu_enable", cfg_sh[1], mmu_enable);
      check_value("remap_enable", cfg_sh[3:2] == 2'b01, remap_enable);
      check_value("gpio_enable", cfg_sh[10:9] == 2'b01, gpio_enable);
      check_value("burst_enable", cfg_sh[11], burst_enable);
      check_value("gpio_data", gpio_sh, gpio_data);
   endtask

   // random sends within credit, random link stalls
   task automatic run_traffic(input int cycles);
      etx_packet_t pkt;
      logic [31:0] r;
      repeat (cycles) begin
         @(posedge clk);
         r = xorshift32();
         if (r[1:0] != 2'b00 && credits[0] > 0) begin
            pkt = make_packet(1'b0);
            exp_wr.push_back(pkt);
            credits[0]--;
            wr_access <= 1'b1;
            wr_packet <= pkt;
         end else
            wr_access <= 1'b0;
         if (r[3:2] != 2'b00 && credits[1] > 0) begin
            pkt = make_packet(1'b1);
            exp_rd.push_back(pkt);
            credits[1]--;
            rd_access <= 1'b1;
            rd_packet <= pkt;
         end else
            rd_access <= 1'b0;
         tx_wait <= (r[6:4] < 3'd3);          // stall about 3 of 8
      end
      @(posedge clk);
      wr_access <= 1'b0;
      rd_access <= 1'b0;
      tx_wait   <= 1'b0;
   endtask

   task automatic drain_link(input string phase);
      int          n;
      logic [31:0] r;
      n = 0;
      while (exp_wr.size() != 0 || exp_rd.size() != 0) begin
         @(posedge clk);
         r = xorshift32();
         tx_wait <= (r[1:0] == 2'b00);
         n++;
         assert (n < DRAIN_LIMIT) else begin
            fail_run($sformatf("%s: link still busy after %0d cycles", phase, n));
         end
      end
      @(posedge clk);
      tx_wait <= 1'b0;
      @(negedge clk);                         // output idle once all beats done
      assert (tx_access === 1'b0) else begin
         fail_run($sformatf("%s: tx_access still high after the last beat", phase));
      end
      check_value({phase, " write credits"}, DEPTH, credits[0]);
      check_value({phase, " read credits"}, DEPTH, credits[1]);
   endtask

   // ##################################################
   // output monitor
   // ##################################################
   always @(posedge clk) read_prev = nreset & mi_en & ~mi_we;

   always @(negedge clk) begin
      etx_packet_t want;
      if (nreset) begin
         if (!read_prev)
            check_value("idle mi_dout", 32'h0, mi_dout);
         if (wr_credit) begin
            assert (credits[0] < DEPTH) else fail_run("write queue returned an extra credit");
            credits[0]++;
         end
         if (rd_credit) begin
            assert (credits[1] < DEPTH) else fail_run("read queue returned an extra credit");
            credits[1]++;
         end
         if (held) begin                      // output frozen under tx_wait
            assert (tx_access === 1'b1) else fail_run("tx_access dropped during tx_wait");
            check_value("tx_packet hold", prev_pkt, tx_packet);
         end
         if (tx_access && !tx_wait) begin     // beat completes next edge
            beats++;
            if (tx_packet.srcaddr[31]) begin
               assert (exp_rd.size() > 0) else fail_run("read beat with nothing pending");
               want = exp_rd.pop_front();
            end else begin
               assert (exp_wr.size() > 0) else fail_run("write beat with nothing pending");
               want = exp_wr.pop_front();
            end
            if (cfg_sh[8])
               want.ctrlmode[3:0] = cfg_sh[7:4];
            check_value("tx_packet", want, tx_packet);
            if (status_quiet && want.dstaddr[31:20] != `ETX_ID) begin
               mon_exp++;
               last_dst       = want.dstaddr;
               last_dst_valid = 1'b1;
            end
         end
         held     = tx_access & tx_wait;
         prev_pkt = tx_packet;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns", WATCHDOG_NS);
      $display("RESULT: FAIL");
      $fatal(1);
   end

   // ##################################################
   // test sequence
   // ##################################################
   initial begin
      logic [31:0] r;
      logic [31:0] d;
      logic [15:0] stat;
      int          beats_at_off;
      rng_state = 32'h881e;
      clk = 1'b0;
      nreset = 1'b0;
      mi_en = 1'b0;
      mi_we = 1'b0;
      mi_addr = '0;
      mi_din = '0;
      wr_access = 1'b0;
      wr_packet = '0;
      rd_access = 1'b0;
      rd_packet = '0;
      tx_wait = 1'b0;
      tx_status = '0;
      credits[0] = DEPTH;
      credits[1] = DEPTH;
      cfg_sh = '0;
      gpio_sh = '0;
      version_sh = `ETX_DEFAULT_VERSION;
      status_sh = '0;
      mon_exp = '0;
      last_dst = '0;
      last_dst_valid = 1'b0;
      status_quiet = 1'b1;
      beats = 0;
      held = 1'b0;
      prev_pkt = '0;
      read_prev = 1'b0;
      repeat (2) @(posedge clk);
      nreset <= 1'b1;

      // reset state
      check_reg("reset version", ETX_REG_VERSION, `ETX_DEFAULT_VERSION);
      check_reg("reset cfg", ETX_REG_CFG, 32'h0);
      check_reg("reset status", ETX_REG_STATUS, 32'h0);
      check_reg("reset monitor", ETX_REG_MONITOR, 32'h0);
      repeat (8) begin
         @(negedge clk);
         assert (tx_access === 1'b0) else fail_run("tx_access high with the link disabled");
      end

      // register writes and readback, tx kept off
      repeat (REG_OPS) begin
         r = xorshift32();
         d = xorshift32();
         case (r[1:0])
            2'd0:    reg_write(ETX_REG_CFG, {d[31:1], 1'b0});
            2'd1:    reg_write(ETX_REG_GPIO, d);
            2'd2:    reg_write(ETX_REG_VERSION, d);
            default: check_reg("unmapped index", {2'b11, r[3:2]}, 32'h0);
         endcase
         check_reg("cfg readback", ETX_REG_CFG, {21'b0, cfg_sh[10:0]});
         check_reg("gpio readback", ETX_REG_GPIO, {23'b0, gpio_sh});
         check_reg("version readback", ETX_REG_VERSION, {16'b0, version_sh});
         check_decoded();
      end

      // traffic, bypass off then on
      for (int ph = 0; ph < 2; ph++) begin
         r = xorshift32();
         reg_write(ETX_REG_CFG, {20'b0, r[11:9], ph[0], r[7:4], r[3:1], 1'b1});
         check_decoded();
         run_traffic(PHASE_CYCLES);
         drain_link("traffic");
      end

      // enable gating
      run_traffic(PHASE_CYCLES / 2);
      reg_write(ETX_REG_CFG, {20'b0, cfg_sh[11:1], 1'b0});
      beats_at_off = beats;
      run_traffic(60);
      assert (beats - beats_at_off <= 1) else begin
         fail_run($sformatf("%0d beats started with tx disabled", beats - beats_at_off));
      end
      reg_write(ETX_REG_CFG, {20'b0, cfg_sh[11:1], 1'b1});
      drain_link("enable gating");

      check_reg("monitor count", ETX_REG_MONITOR, mon_exp);
      if (last_dst_valid)
         check_reg("sampled dstaddr", ETX_REG_PACKET, last_dst);

      // status bit 6 high stalls the monitor
      r = xorshift32();
      stat = r[15:0] | 16'h0040;
      @(posedge clk);
      tx_status <= stat;
      repeat (5) @(posedge clk);              // past the sync flops
      status_quiet = 1'b0;
      status_sh    = status_sh | stat;
      reg_write(ETX_REG_MONITOR, xorshift32());
      run_traffic(PHASE_CYCLES / 2);
      drain_link("status hold");
      check_reg("monitor stalled", ETX_REG_MONITOR, mon_exp);
      @(posedge clk);
      tx_status <= '0;
      repeat (5) @(posedge clk);
      status_quiet = 1'b1;
      check_reg("sticky status", ETX_REG_STATUS, {16'b0, status_sh});
      reg_write(ETX_REG_STATUS, 32'h0);
      check_reg("status cleared", ETX_REG_STATUS, 32'h0);

      // monitor counts again
      run_traffic(PHASE_CYCLES);
      drain_link("monitor");
      check_reg("monitor count", ETX_REG_MONITOR, mon_exp);
      if (last_dst_valid)
         check_reg("sampled dstaddr", ETX_REG_PACKET, last_dst);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* flist.f */
+incdir+common
common/etx_pkg.sv
common/mi_if.sv
verilog/etx_queue.sv
verilog/etx_arbiter.sv
etx_cfg/etx_cfg.sv
verilog/etx_top.sv
dv/etx_tb.sv

/* run.sh */
#!/bin/sh
# build the mesh tx testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module etx_tb -f flist.f \
   && ./obj_dir/Vetx_tb | tee /dev/stderr | grep -q "^RESULT: PASS$" \
   && echo "etx_tb passed" \
   || { echo "etx_tb failed"; exit 1; }
